//--- verilog/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// Character format
////////////////////////////////////////////////////////////////////////

// Data bits per character, 8N1 frame
`define UART_DATA_BITS 8

// Ticks per bit on the line
`define UART_OVERSAMPLE 16

// Clocks per oversample tick
`define UART_TICK_DIV 2

`endif

//--- verilog/uart_pkg.sv
package uart_pkg;

	////////////////////////////////////////////////////////////////////////
	// Host command set
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_NOP         = 2'd0,
		OP_WRITE_TX    = 2'd1,
		OP_READ_RX     = 2'd2,
		OP_READ_STATUS = 2'd3
	} host_op_t;

	// Frame phase, shared by serializer and deserializer
	typedef enum logic [1:0] {
		LINE_IDLE,
		LINE_START,
		LINE_DATA,
		LINE_STOP
	} line_state_t;

	// Status word bit positions, upper bits read zero
	localparam int unsigned ST_TX_FULL    = 0;
	localparam int unsigned ST_TX_BUSY    = 1;
	localparam int unsigned ST_RX_VALID   = 2;
	localparam int unsigned ST_RX_OVERRUN = 3;
	localparam int unsigned ST_FRAME_ERR  = 4;
	localparam int unsigned ST_TX_DROPPED = 5;

endpackage

//--- verilog/baud_tick_gen.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module baud_tick_gen
(
	input  logic clk,
	input  logic arst_n,
	output logic tick
);

	// Counter width, at least one bit
	localparam int CNT_W = (`UART_TICK_DIV > 1) ? $clog2(`UART_TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_TICK_DIV - 1);

	logic [CNT_W-1:0] div_cnt;

	// Free-running divider, tick on the wrap
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end
		else
		begin
			tick <= (div_cnt == CNT_LAST);
			if (div_cnt == CNT_LAST)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

//--- verilog/tx_holding_buffer.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module tx_holding_buffer
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       tx_wr,
	input  logic [`UART_DATA_BITS-1:0] tx_wdata,
	input  logic                       tx_busy,
	output logic                       tx_full,
	output logic                       tx_start,
	output logic [`UART_DATA_BITS-1:0] tx_data
);

	// Single entry, either waiting for a byte or holding one
	typedef enum logic {
		BUF_EMPTY,
		BUF_LOADED
	} buf_state_t;

	buf_state_t state;

	////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= BUF_EMPTY;
			tx_full  <= 1'b0;
			tx_start <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0;
			case (state)
				BUF_EMPTY:
				begin
					// Host write gated against tx_full upstream
					if (tx_wr)
					begin
						state   <= BUF_LOADED;
						tx_full <= 1'b1;
					end
				end
				BUF_LOADED:
				begin
					// Hand off once the serializer is free
					if (!tx_busy)
					begin
						state    <= BUF_EMPTY;
						tx_full  <= 1'b0;
						tx_start <= 1'b1;
					end
				end
				default: state <= BUF_EMPTY;
			endcase
		end
	end

	// Held byte, serializer samples it on tx_start
	always_ff @(posedge clk)
	begin
		if (tx_wr && (state == BUF_EMPTY))
			tx_data <= tx_wdata;
	end

endmodule

//--- verilog/tx_serializer.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module tx_serializer
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       tick,
	input  logic                       tx_start,
	input  logic [`UART_DATA_BITS-1:0] tx_data,
	output logic                       txd,
	output logic                       tx_busy
);

	import uart_pkg::*;

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	line_state_t state;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_W-1:0] bit_idx;
	logic [`UART_DATA_BITS-1:0] shift_reg;
	logic bit_end;

	// Last tick of the current bit
	assign bit_end = tick && (tick_cnt == TICK_LAST);

	////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= LINE_IDLE;
			txd      <= 1'b1;
			tx_busy  <= 1'b0;
			tick_cnt <= '0;
			bit_idx  <= '0;
		end
		else
		begin
			if (state != LINE_IDLE && tick)
				tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
			case (state)
				LINE_IDLE:
				begin
					// Busy from tx_start, start bit waits for a tick
					if (tx_start)
						tx_busy <= 1'b1;
					else if (tx_busy && tick)
					begin
						state    <= LINE_START;
						txd      <= 1'b0;
						tick_cnt <= '0;
					end
				end
				LINE_START:
				begin
					if (bit_end)
					begin
						state   <= LINE_DATA;
						txd     <= shift_reg[0];
						bit_idx <= '0;
					end
				end
				LINE_DATA:
				begin
					if (bit_end)
					begin
						if (bit_idx == BIT_LAST)
						begin
							state <= LINE_STOP;
							txd   <= 1'b1;
						end
						else
						begin
							txd     <= shift_reg[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				LINE_STOP:
				begin
					// Line already high, just release
					if (bit_end)
					begin
						state   <= LINE_IDLE;
						tx_busy <= 1'b0;
					end
				end
				default: state <= LINE_IDLE;
			endcase
		end
	end

	// LSB first, next bit always at position 0
	always_ff @(posedge clk)
	begin
		if (tx_start)
			shift_reg <= tx_data;
		else if (bit_end && (state == LINE_START || state == LINE_DATA))
			shift_reg <= shift_reg >> 1;
	end

endmodule

//--- verilog/rx_deserializer.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module rx_deserializer
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       tick,
	input  logic                       rxd,
	output logic                       rx_strobe,
	output logic                       frame_ok,
	output logic [`UART_DATA_BITS-1:0] rx_data
);

	import uart_pkg::*;

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	line_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_W-1:0] bit_idx;
	logic sample_now;

	// Mid-bit of data and stop, one full bit after the previous sample
	assign sample_now = tick && (tick_cnt == TICK_LAST);

	////////////////////////////////////////////////////////////////////////
	// Line synchronizer, idle high
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= LINE_IDLE;
			tick_cnt  <= '0;
			bit_idx   <= '0;
			rx_strobe <= 1'b0;
			frame_ok  <= 1'b0;
		end
		else
		begin
			rx_strobe <= 1'b0;
			if (state != LINE_IDLE && tick)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				LINE_IDLE:
				begin
					// Falling edge starts the frame
					if (rx_prev && !rx_sync)
					begin
						state    <= LINE_START;
						tick_cnt <= '0;
					end
				end
				LINE_START:
				begin
					// High at mid-bit means a glitch
					if (tick && tick_cnt == TICK_HALF)
					begin
						state    <= rx_sync ? LINE_IDLE : LINE_DATA;
						tick_cnt <= '0;
						bit_idx  <= '0;
					end
				end
				LINE_DATA:
				begin
					if (sample_now)
					begin
						if (bit_idx == BIT_LAST)
							state <= LINE_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end
				end
				LINE_STOP:
				begin
					// Report at mid stop bit, low stop is a frame error
					if (sample_now)
					begin
						state     <= LINE_IDLE;
						rx_strobe <= 1'b1;
						frame_ok  <= rx_sync;
					end
				end
				default: state <= LINE_IDLE;
			endcase
		end
	end

	// Shift in from the top, LSB arrives first
	always_ff @(posedge clk)
	begin
		if (state == LINE_DATA && sample_now)
			rx_data <= {rx_sync, rx_data[`UART_DATA_BITS-1:1]};
	end

endmodule

//--- verilog/uart_host_regs.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_host_regs
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       cmd_valid,
	input  uart_pkg::host_op_t         cmd_op,
	input  logic [`UART_DATA_BITS-1:0] cmd_wdata,
	input  logic                       tx_full,
	input  logic                       tx_busy,
	input  logic                       rx_strobe,
	input  logic                       frame_ok,
	input  logic [`UART_DATA_BITS-1:0] rx_data,
	output logic                       tx_wr,
	output logic [`UART_DATA_BITS-1:0] tx_wdata,
	output logic                       rsp_valid,
	output logic [`UART_DATA_BITS-1:0] rsp_data
);

	import uart_pkg::*;

	logic is_write;
	logic is_read_rx;
	logic is_read_st;
	logic rx_valid;
	logic rx_overrun;
	logic frame_err;
	logic tx_dropped;
	logic [`UART_DATA_BITS-1:0] rx_buf;
	logic [`UART_DATA_BITS-1:0] status;

	// Command decode
	assign is_write   = cmd_valid && (cmd_op == OP_WRITE_TX);
	assign is_read_rx = cmd_valid && (cmd_op == OP_READ_RX);
	assign is_read_st = cmd_valid && (cmd_op == OP_READ_STATUS);

	// Write goes straight to the buffer when it has room
	assign tx_wr    = is_write && !tx_full;
	assign tx_wdata = cmd_wdata;

	// Status word from both paths
	always_comb
	begin
		status                = '0;
		status[ST_TX_FULL]    = tx_full;
		status[ST_TX_BUSY]    = tx_busy;
		status[ST_RX_VALID]   = rx_valid;
		status[ST_RX_OVERRUN] = rx_overrun;
		status[ST_FRAME_ERR]  = frame_err;
		status[ST_TX_DROPPED] = tx_dropped;
	end

	////////////////////////////////////////////////////////////////////////
	// Sticky flags and response
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_valid   <= 1'b0;
			rx_overrun <= 1'b0;
			frame_err  <= 1'b0;
			tx_dropped <= 1'b0;
			rsp_valid  <= 1'b0;
			rsp_data   <= '0;
		end
		else
		begin
			// Reads clear first, a new byte sets again
			if (is_read_rx)
			begin
				rx_valid   <= 1'b0;
				rx_overrun <= 1'b0;
				frame_err  <= 1'b0;
			end
			if (rx_strobe)
			begin
				rx_valid <= 1'b1;
				if (rx_valid && !is_read_rx)
					rx_overrun <= 1'b1;
				if (!frame_ok)
					frame_err <= 1'b1;
			end
			// Write that found the buffer full
			if (is_write && tx_full)
				tx_dropped <= 1'b1;
			else if (is_read_st)
				tx_dropped <= 1'b0;
			rsp_valid <= cmd_valid;
			if (is_read_rx)
				rsp_data <= rx_buf;
			else if (is_read_st)
				rsp_data <= status;
			else
				rsp_data <= '0;
		end
	end

	// Latest byte wins on overrun
	always_ff @(posedge clk)
	begin
		if (rx_strobe)
			rx_buf <= rx_data;
	end

endmodule

//--- verilog/uart_top.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_top
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       cmd_valid,
	input  uart_pkg::host_op_t         cmd_op,
	input  logic [`UART_DATA_BITS-1:0] cmd_wdata,
	input  logic                       rxd,
	output logic                       rsp_valid,
	output logic                       txd,
	output logic [`UART_DATA_BITS-1:0] rsp_data
);

	logic tick;
	logic tx_wr;
	logic tx_full;
	logic tx_start;
	logic tx_busy;
	logic rx_strobe;
	logic frame_ok;
	logic [`UART_DATA_BITS-1:0] tx_wdata;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic [`UART_DATA_BITS-1:0] rx_data;

	// Shared time base
	baud_tick_gen baud_tick_gen_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.tick   (tick)
	);

	// Transmit path
	tx_holding_buffer tx_holding_buffer_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.tx_wr    (tx_wr),
		.tx_wdata (tx_wdata),
		.tx_busy  (tx_busy),
		.tx_full  (tx_full),
		.tx_start (tx_start),
		.tx_data  (tx_data)
	);

	tx_serializer tx_serializer_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.tick     (tick),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.txd      (txd),
		.tx_busy  (tx_busy)
	);

	// Receive path
	rx_deserializer rx_deserializer_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.tick      (tick),
		.rxd       (rxd),
		.rx_strobe (rx_strobe),
		.frame_ok  (frame_ok),
		.rx_data   (rx_data)
	);

	// Host side
	uart_host_regs uart_host_regs_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_wdata (cmd_wdata),
		.tx_full   (tx_full),
		.tx_busy   (tx_busy),
		.rx_strobe (rx_strobe),
		.frame_ok  (frame_ok),
		.rx_data   (rx_data),
		.tx_wr     (tx_wr),
		.tx_wdata  (tx_wdata),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data)
	);

endmodule

//--- testbench/tb_uart_top.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module tb_uart_top;

	import uart_pkg::*;

	// Clocks per bit on the line, 32 with the default settings
	localparam int BIT_CLKS   = `UART_OVERSAMPLE * `UART_TICK_DIV;
	localparam int WAIT_LIMIT = 2000;

	// Text fields from the trace, right-justified by $sscanf
	typedef logic [8*16-1:0] text_t;
	typedef logic [`UART_DATA_BITS-1:0] byte_t;

	logic     clk;
	logic     arst_n;
	logic     cmd_valid;
	host_op_t cmd_op;
	byte_t    cmd_wdata;
	logic     rxd;
	logic     rsp_valid;
	logic     txd;
	byte_t    rsp_data;

	// Line source select, loopback unless a frame is forced
	logic forced_mode;
	logic forced_rxd;

	assign rxd = forced_mode ? forced_rxd : txd;

	uart_top uart_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_wdata (cmd_wdata),
		.rxd       (rxd),
		.rsp_valid (rsp_valid),
		.txd       (txd),
		.rsp_data  (rsp_data)
	);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	// Data byte from OP_READ_RX, or zero from write and nop
	task automatic check_data(input text_t name, input byte_t exp_val, input byte_t act_val);
		if (act_val !== exp_val)
		begin
			$display("[ERROR] %0s: expected data 0x%h, actual 0x%h", name, exp_val, act_val);
			abort_run();
		end
	endtask

	// Whole status word, all six flags and the zero upper bits
	task automatic check_status(input text_t name, input byte_t exp_val, input byte_t act_val);
		if (act_val !== exp_val)
		begin
			$display("[ERROR] %0s: expected status 0x%h, actual 0x%h", name, exp_val, act_val);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host and line drivers
	//////////////////////////////////////////////////////////////////////

	// One strobe, response sampled at the falling edge one cycle later
	task automatic send_command(input text_t name, input host_op_t op, input byte_t wdata,
		output byte_t data);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		cmd_wdata <= wdata;
		@(posedge clk);
		cmd_valid <= 1'b0;
		cmd_op    <= OP_NOP;
		cmd_wdata <= '0;
		@(negedge clk);
		if (rsp_valid !== 1'b1)
		begin
			$display("%0s: no response one clock after the command strobe", name);
			abort_run();
		end
		data = rsp_data;
	endtask

	// Repeat status reads until the masked bits match
	task automatic poll_status(input text_t name, input byte_t mask, input byte_t value);
		byte_t status;
		int cycles;
		logic hit;
		cycles = 0;
		hit    = 1'b0;
		while (!hit && cycles < WAIT_LIMIT)
		begin
			send_command(name, OP_READ_STATUS, '0, status);
			hit    = ((status & mask) == value);
			// Each status read spans two clocks
			cycles = cycles + 2;
		end
		if (!hit)
		begin
			$display("%0s: status bits 0x%h did not reach 0x%h within %0d cycles",
				name, mask, value, WAIT_LIMIT);
			abort_run();
		end
	endtask

	// Start bit, data LSB first, chosen stop bit, then idle high
	task automatic drive_frame(input byte_t data, input logic stop_bit);
		logic [`UART_DATA_BITS+1:0] frame;
		int b;
		frame = {stop_bit, data, 1'b0};
		for (b = 0; b < `UART_DATA_BITS + 2; b++)
		begin
			@(posedge clk);
			forced_rxd <= frame[b];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		forced_rxd <= 1'b1;
	endtask

	// One trace line
	task automatic run_step(input text_t name, input text_t op_text, input byte_t wdata,
		input text_t mode_text, input byte_t exp_val);
		byte_t rsp;
		logic want_forced;
		want_forced = (mode_text == "F");
		if (want_forced !== forced_mode)
		begin
			@(posedge clk);
			forced_mode <= want_forced;
		end
		if (op_text == "WR")
		begin
			send_command(name, OP_WRITE_TX, wdata, rsp);
			check_data(name, exp_val, rsp);
		end
		else if (op_text == "RX")
		begin
			send_command(name, OP_READ_RX, wdata, rsp);
			check_data(name, exp_val, rsp);
		end
		else if (op_text == "ST")
		begin
			send_command(name, OP_READ_STATUS, wdata, rsp);
			check_status(name, exp_val, rsp);
		end
		else if (op_text == "NOP")
		begin
			send_command(name, OP_NOP, wdata, rsp);
			check_data(name, exp_val, rsp);
		end
		else if (op_text == "POLL")
			poll_status(name, wdata, exp_val);
		else if (op_text == "FRAME")
			drive_frame(wdata, exp_val[0]);
		else
		begin
			$display("%0s: unknown operation %0s in the trace", name, op_text);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin : main
		int fd;
		int n;
		int steps;
		logic [8*128-1:0] line_buf;
		text_t test_name;
		text_t op_text;
		text_t mode_text;
		byte_t wdata;
		byte_t exp_val;

		arst_n      = 1'b0;
		cmd_valid   = 1'b0;
		cmd_op      = OP_NOP;
		cmd_wdata   = '0;
		forced_mode = 1'b0;
		forced_rxd  = 1'b1;
		steps       = 0;

		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		fd = $fopen("testbench/uart_trace.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file testbench/uart_trace.txt");
			abort_run();
		end

		while (!$feof(fd))
		begin
			line_buf = '0;
			n = $fgets(line_buf, fd);
			if (n > 0)
				n = $sscanf(line_buf, "%s %s %h %s %h",
					test_name, op_text, wdata, mode_text, exp_val);
			// Skip blank lines and lines opening with a lone #
			if (n > 0 && test_name != "#")
			begin
				if (n != 5)
				begin
					$display("Malformed trace line for %0s", test_name);
					abort_run();
				end
				run_step(test_name, op_text, wdata, mode_text, exp_val);
				steps++;
			end
		end
		$fclose(fd);

		if (steps == 0)
		begin
			$display("The trace file held no commands");
			abort_run();
		end
		else
		begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

//--- testbench/uart_trace.txt
# name op wdata mode expect, hex values, mode L loopback or F forced line
# POLL waits for status and mask equal to expect, FRAME drives wdata with expect as stop bit
reset_status ST    00 L 00
reset_nop    NOP   00 L 00
loopback     WR    a5 L 00
loopback     POLL  04 L 04
loopback     RX    00 L a5
loopback     POLL  02 L 00
loopback     ST    00 L 00
overrun      WR    11 L 00
overrun      POLL  01 L 00
overrun      WR    22 L 00
overrun      POLL  08 L 08
overrun      POLL  02 L 00
overrun      ST    00 L 0c
overrun      RX    00 L 22
overrun      ST    00 L 00
dropped      WR    41 L 00
dropped      POLL  02 L 02
dropped      WR    42 L 00
dropped      WR    43 L 00
dropped      ST    00 L 23
dropped      ST    00 L 03
dropped      POLL  04 L 04
dropped      RX    00 L 41
dropped      POLL  04 L 04
dropped      RX    00 L 42
dropped      POLL  02 L 00
dropped      ST    00 L 00
frame_err    FRAME 3c F 00
frame_err    POLL  04 F 04
frame_err    ST    00 F 14
frame_err    RX    00 F 3c
frame_err    ST    00 F 00

//--- src.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/tx_holding_buffer.sv
verilog/tx_serializer.sv
verilog/rx_deserializer.sv
verilog/uart_host_regs.sv
verilog/uart_top.sv
testbench/tb_uart_top.sv

//--- Bender.yml
package:
  name: uart_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_pkg.sv
      - verilog/baud_tick_gen.sv
      - verilog/tx_holding_buffer.sv
      - verilog/tx_serializer.sv
      - verilog/rx_deserializer.sv
      - verilog/uart_host_regs.sv
      - verilog/uart_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_uart_top.sv
